// File: rtl/apb_subsystem_pkg.sv
// Word accesses only; slot field is haddr[15:12], register field is haddr[4:2]
package apb_subsystem_pkg;

  // ============================================================
  // Bus widths
  // ============================================================
  localparam int ADDR_W = 32;  // AHB and APB address
  localparam int DATA_W = 32;  // AHB and APB data

  // Slot field in the AHB address
  localparam int SLOT_LSB = 12;
  localparam int SLOT_W   = 4;
  localparam logic [SLOT_W-1:0] SLOT_GPIO0 = 4'd0;  // 16 pin block
  localparam logic [SLOT_W-1:0] SLOT_GPIO1 = 4'd1;  // 8 pin block

  // Register word offset field
  localparam int OFF_LSB = 2;
  localparam int OFF_W   = 3;

  // AHB transfer types
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // ============================================================
  // GPIO register map, word offsets
  // ============================================================
  localparam logic [OFF_W-1:0] REG_DATA_OUT = 3'd0;  // Byte 0x00
  localparam logic [OFF_W-1:0] REG_DIR      = 3'd1;  // Byte 0x04, 1 = drive
  localparam logic [OFF_W-1:0] REG_DATA_IN  = 3'd2;  // Byte 0x08, read only
  localparam logic [OFF_W-1:0] REG_IRQ_MASK = 3'd3;  // Byte 0x0C
  localparam logic [OFF_W-1:0] REG_IRQ_STAT = 3'd4;  // Byte 0x10, W1C

  // Default pin widths per slot
  localparam int GPIO0_W = 16;
  localparam int GPIO1_W = 8;

endpackage

// File: rtl/ahb_addr_decode.sv
// Word transfers only; haddr bits outside 15:12 and 4:2 are ignored, one request at a time
`timescale 1ns/1ps

module ahb_addr_decode (
  input  logic                                  tb_hclk23,
  input  logic                                  hresetn23,
  input  logic                                  i_hsel,
  input  logic [apb_subsystem_pkg::ADDR_W-1:0]  i_haddr,
  input  logic [1:0]                            i_htrans,
  input  logic                                  i_hwrite,
  input  logic                                  i_hready,   // Bridge ready fed back
  output logic                                  o_req_valid,
  output logic                                  o_req_slot,
  output logic [apb_subsystem_pkg::OFF_W-1:0]   o_req_offset,
  output logic                                  o_req_write,
  output logic                                  o_req_err
);

  logic                                trans_active;  // NONSEQ or SEQ
  logic                                accept;        // Address phase taken this edge
  logic [apb_subsystem_pkg::SLOT_W-1:0] slot_field;
  logic                                hit_gpio0;
  logic                                hit_gpio1;

  // ============================================================
  // Address phase qualification
  // ============================================================
  always_comb begin
    case (i_htrans)
      apb_subsystem_pkg::HTRANS_NONSEQ,
      apb_subsystem_pkg::HTRANS_SEQ:    trans_active = 1'b1;
      apb_subsystem_pkg::HTRANS_IDLE,
      apb_subsystem_pkg::HTRANS_BUSY:   trans_active = 1'b0;  // No request
      default:                          trans_active = 1'b0;
    endcase
  end

  assign accept = i_hsel && trans_active && i_hready;

  // Slot decode
  assign slot_field = i_haddr[apb_subsystem_pkg::SLOT_LSB +: apb_subsystem_pkg::SLOT_W];
  assign hit_gpio0  = (slot_field == apb_subsystem_pkg::SLOT_GPIO0);
  assign hit_gpio1  = (slot_field == apb_subsystem_pkg::SLOT_GPIO1);

  // Valid pulse lasts one cycle since ready drops behind it
  always_ff @(posedge tb_hclk23) begin
    if (!hresetn23) begin
      o_req_valid <= 1'b0;
    end else begin
      o_req_valid <= accept;
    end
  end

  // Request fields stay put until the next accept
  // so the bridge still sees them in the access cycle
  always_ff @(posedge tb_hclk23) begin
    if (accept) begin
      o_req_slot   <= hit_gpio1;
      o_req_offset <= i_haddr[apb_subsystem_pkg::OFF_LSB +: apb_subsystem_pkg::OFF_W];
      o_req_write  <= i_hwrite;
      o_req_err    <= !(hit_gpio0 || hit_gpio1);  // Unmapped slot
    end
  end

endmodule

// File: rtl/apb_bridge_fsm.sv
// Zero wait state APB slaves only (no pready); hresp is the one bit AHB-Lite form
`timescale 1ns/1ps

module apb_bridge_fsm (
  input  logic                                 tb_hclk23,
  input  logic                                 hresetn23,
  input  logic                                 i_req_valid,   // Marks the setup cycle
  input  logic                                 i_req_slot,
  input  logic [apb_subsystem_pkg::OFF_W-1:0]  i_req_offset,
  input  logic                                 i_req_write,
  input  logic                                 i_req_err,
  input  logic [apb_subsystem_pkg::DATA_W-1:0] i_hwdata,
  input  logic [apb_subsystem_pkg::DATA_W-1:0] i_prdata0,
  input  logic [apb_subsystem_pkg::DATA_W-1:0] i_prdata1,
  output logic                                 o_psel0,
  output logic                                 o_psel1,
  output logic                                 o_penable,
  output logic                                 o_pwrite,
  output logic [apb_subsystem_pkg::OFF_W-1:0]  o_paddr,
  output logic [apb_subsystem_pkg::DATA_W-1:0] o_pwdata,
  output logic [apb_subsystem_pkg::DATA_W-1:0] o_hrdata,
  output logic                                 o_hready,
  output logic                                 o_hresp
);

  // ============================================================
  // States
  // ============================================================
  // SETUP doubles as ERR1 and ACCESS as ERR2, told apart by i_req_err
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  logic [1:0]                          st_q;     // Registered state
  logic [1:0]                          st;       // Current state seen by outputs
  logic [1:0]                          st_d;
  logic                                xfer;     // Mapped transfer in flight
  logic [apb_subsystem_pkg::DATA_W-1:0] wdata_q;  // Write data held for access

  // A fresh request always means setup this cycle
  assign st = i_req_valid ? ST_SETUP : st_q;

  always_comb begin
    case (st)
      ST_SETUP:  st_d = ST_ACCESS;  // Setup is always one cycle
      ST_ACCESS: st_d = ST_IDLE;    // No pready, so access ends here
      default:   st_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge tb_hclk23) begin
    if (!hresetn23) begin
      st_q <= ST_IDLE;
    end else begin
      st_q <= st_d;
    end
  end

  // ============================================================
  // APB side
  // ============================================================
  assign xfer      = (st != ST_IDLE) && !i_req_err;
  assign o_psel0   = xfer && !i_req_slot;
  assign o_psel1   = xfer && i_req_slot;
  assign o_penable = xfer && (st == ST_ACCESS);  // Second APB cycle
  assign o_pwrite  = i_req_write;
  assign o_paddr   = i_req_offset;

  // hwdata first shows up in setup, captured at its end
  always_ff @(posedge tb_hclk23) begin
    if (st == ST_SETUP) begin
      wdata_q <= i_hwdata;
    end
  end

  assign o_pwdata = (st == ST_ACCESS) ? wdata_q : i_hwdata;

  // ============================================================
  // AHB response
  // ============================================================
  assign o_hready = (st != ST_SETUP);                // Low for exactly one cycle
  assign o_hresp  = (st != ST_IDLE) && i_req_err;    // Two cycle ERROR

  // Read data of the addressed slot, zero otherwise
  always_comb begin
    o_hrdata = '0;
    if (xfer && (st == ST_ACCESS)) begin
      o_hrdata = i_req_slot ? i_prdata1 : i_prdata0;
    end
  end

endmodule

// File: rtl/apb_gpio.sv
// PIN_W from 1 to 32; bits above PIN_W read zero; input pins are asynchronous and get synchronized
`timescale 1ns/1ps

module apb_gpio #(
  parameter int PIN_W = 16
) (
  input  logic                                 tb_hclk23,
  input  logic                                 hresetn23,
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [apb_subsystem_pkg::OFF_W-1:0]  i_paddr,
  input  logic [apb_subsystem_pkg::DATA_W-1:0] i_pwdata,
  input  logic [PIN_W-1:0]                     i_pins,
  output logic [apb_subsystem_pkg::DATA_W-1:0] o_prdata,
  output logic [PIN_W-1:0]                     o_pins_out,
  output logic [PIN_W-1:0]                     o_pins_oe,
  output logic                                 o_irq
);

  logic [PIN_W-1:0] dout_q;    // REG_DATA_OUT
  logic [PIN_W-1:0] dir_q;     // REG_DIR
  logic [PIN_W-1:0] mask_q;    // REG_IRQ_MASK
  logic [PIN_W-1:0] stat_q;    // REG_IRQ_STAT, sticky
  logic [PIN_W-1:0] sync1_q;   // First synchronizer stage
  logic [PIN_W-1:0] sync2_q;   // Seen as REG_DATA_IN
  logic [PIN_W-1:0] prev_q;    // Last synchronized value
  logic [PIN_W-1:0] rise;
  logic [PIN_W-1:0] clr;       // W1C bits
  logic [PIN_W-1:0] wr_bits;
  logic             wr_en;     // Write at end of access

  // ============================================================
  // Register writes
  // ============================================================
  assign wr_en   = i_psel && i_penable && i_pwrite;
  assign wr_bits = i_pwdata[PIN_W-1:0];
  assign rise    = sync2_q & ~prev_q;
  assign clr     = (wr_en && (i_paddr == apb_subsystem_pkg::REG_IRQ_STAT)) ? wr_bits : '0;

  always_ff @(posedge tb_hclk23) begin
    if (!hresetn23) begin
      dout_q  <= '0;
      dir_q   <= '0;
      mask_q  <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_pins;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      stat_q  <= (stat_q & ~clr) | rise;  // New edge beats the clear
      if (wr_en && (i_paddr == apb_subsystem_pkg::REG_DATA_OUT)) dout_q <= wr_bits;
      if (wr_en && (i_paddr == apb_subsystem_pkg::REG_DIR))      dir_q  <= wr_bits;
      if (wr_en && (i_paddr == apb_subsystem_pkg::REG_IRQ_MASK)) mask_q <= wr_bits;
    end
  end

  // Read mux, zero extended to the bus
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      apb_subsystem_pkg::REG_DATA_OUT: o_prdata[PIN_W-1:0] = dout_q;
      apb_subsystem_pkg::REG_DIR:      o_prdata[PIN_W-1:0] = dir_q;
      apb_subsystem_pkg::REG_DATA_IN:  o_prdata[PIN_W-1:0] = sync2_q;
      apb_subsystem_pkg::REG_IRQ_MASK: o_prdata[PIN_W-1:0] = mask_q;
      apb_subsystem_pkg::REG_IRQ_STAT: o_prdata[PIN_W-1:0] = stat_q;
      default:                         o_prdata = '0;  // Unused offsets
    endcase
  end

  assign o_pins_out = dout_q;
  assign o_pins_oe  = dir_q;
  assign o_irq      = |(stat_q & mask_q);

endmodule

// File: rtl/apb_subsystem.sv
// Single AHB master, word transfers only; slot 0 and 1 are GPIO, other slots answer ERROR
`timescale 1ns/1ps

module apb_subsystem #(
  parameter int GPIO0_W = apb_subsystem_pkg::GPIO0_W,
  parameter int GPIO1_W = apb_subsystem_pkg::GPIO1_W
) (
  input  logic                                 tb_hclk23,
  input  logic                                 hresetn23,
  input  logic                                 i_hsel,
  input  logic [apb_subsystem_pkg::ADDR_W-1:0] i_haddr,
  input  logic [1:0]                           i_htrans,
  input  logic                                 i_hwrite,
  input  logic [apb_subsystem_pkg::DATA_W-1:0] i_hwdata,
  output logic [apb_subsystem_pkg::DATA_W-1:0] o_hrdata,
  output logic                                 o_hready,
  output logic                                 o_hresp,
  input  logic [GPIO0_W-1:0]                   i_gpio0_in,
  output logic [GPIO0_W-1:0]                   o_gpio0_out,
  output logic [GPIO0_W-1:0]                   o_gpio0_oe,
  input  logic [GPIO1_W-1:0]                   i_gpio1_in,
  output logic [GPIO1_W-1:0]                   o_gpio1_out,
  output logic [GPIO1_W-1:0]                   o_gpio1_oe,
  output logic                                 o_irq
);

  // ============================================================
  // Internal wiring
  // ============================================================
  logic                                 req_valid;
  logic                                 req_slot;
  logic [apb_subsystem_pkg::OFF_W-1:0]  req_offset;
  logic                                 req_write;
  logic                                 req_err;
  logic                                 psel0;
  logic                                 psel1;
  logic                                 penable;
  logic                                 pwrite;
  logic [apb_subsystem_pkg::OFF_W-1:0]  paddr;
  logic [apb_subsystem_pkg::DATA_W-1:0] pwdata;
  logic [apb_subsystem_pkg::DATA_W-1:0] prdata0;
  logic [apb_subsystem_pkg::DATA_W-1:0] prdata1;
  logic                                 irq0;
  logic                                 irq1;

  // Decode stage, ready comes straight back from the bridge
  ahb_addr_decode i_decode (
    .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
    .i_hsel(i_hsel), .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hwrite(i_hwrite),
    .i_hready(o_hready),
    .o_req_valid(req_valid), .o_req_slot(req_slot), .o_req_offset(req_offset),
    .o_req_write(req_write), .o_req_err(req_err)
  );

  apb_bridge_fsm i_bridge (
    .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
    .i_req_valid(req_valid), .i_req_slot(req_slot), .i_req_offset(req_offset),
    .i_req_write(req_write), .i_req_err(req_err), .i_hwdata(i_hwdata),
    .i_prdata0(prdata0), .i_prdata1(prdata1),
    .o_psel0(psel0), .o_psel1(psel1), .o_penable(penable), .o_pwrite(pwrite),
    .o_paddr(paddr), .o_pwdata(pwdata),
    .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp)
  );

  apb_gpio #(.PIN_W(GPIO0_W)) i_gpio0 (  // Slot 0
    .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
    .i_psel(psel0), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
    .i_pwdata(pwdata), .i_pins(i_gpio0_in),
    .o_prdata(prdata0), .o_pins_out(o_gpio0_out), .o_pins_oe(o_gpio0_oe), .o_irq(irq0)
  );

  apb_gpio #(.PIN_W(GPIO1_W)) i_gpio1 (  // Slot 1
    .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
    .i_psel(psel1), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
    .i_pwdata(pwdata), .i_pins(i_gpio1_in),
    .o_prdata(prdata1), .o_pins_out(o_gpio1_out), .o_pins_oe(o_gpio1_oe), .o_irq(irq1)
  );

  assign o_irq = irq0 | irq1;  // Shared interrupt line

endmodule

// File: tests/apb_subsystem_checker.sv
// Bound into apb_bridge_fsm; the checks assume zero wait state APB slaves and a single master
`timescale 1ns/1ps

module apb_subsystem_checker (
  input logic tb_hclk23,
  input logic hresetn23,
  input logic i_psel0,
  input logic i_psel1,
  input logic i_penable,
  input logic i_hready,
  input logic i_hresp
);

  logic any_sel;  // Either slot selected

  assign any_sel = i_psel0 || i_psel1;

  // ============================================================
  // APB phases
  // ============================================================
  a_setup_then_access: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    any_sel && !i_penable |=> any_sel && i_penable)
    else $error("APB setup cycle not followed by access");

  a_access_after_setup: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    i_penable |-> $past(any_sel && !i_penable))
    else $error("penable high without a preceding setup cycle");

  a_one_sel: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    $onehot0({i_psel0, i_psel1}))
    else $error("More than one psel high");

  // ============================================================
  // AHB error response
  // ============================================================
  a_no_sel_on_err: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    i_hresp |-> !any_sel)
    else $error("hresp raised together with a psel");

  a_err_first: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    $rose(i_hresp) |-> !i_hready)
    else $error("Error response did not start with hready low");

  a_err_second: assert property (@(posedge tb_hclk23) disable iff (!hresetn23)
    i_hresp && !i_hready |=> i_hresp && i_hready)
    else $error("Error response second cycle wrong");

endmodule

bind apb_bridge_fsm apb_subsystem_checker i_checker (
  .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
  .i_psel0(o_psel0), .i_psel1(o_psel1), .i_penable(o_penable),
  .i_hready(o_hready), .i_hresp(o_hresp)
);

// File: tests/tb_apb_subsystem.sv
// Pins change only while the bus idles and then settle 4 cycles; one transfer in data phase at a time
`timescale 1ns/1ps

module tb_apb_subsystem;

  localparam int W0          = 16;   // Slot 0 pins
  localparam int W1          = 8;    // Slot 1 pins
  localparam int NUM_STEPS   = 800;
  localparam int READY_LIMIT = 8;    // Max low cycles before timeout

  logic        tb_hclk23;
  logic        hresetn23;
  logic        i_hsel;
  logic [31:0] i_haddr;
  logic [1:0]  i_htrans;
  logic        i_hwrite;
  logic [31:0] i_hwdata;
  logic [31:0] o_hrdata;
  logic        o_hready;
  logic        o_hresp;
  logic [W0-1:0] i_gpio0_in;
  logic [W0-1:0] o_gpio0_out;
  logic [W0-1:0] o_gpio0_oe;
  logic [W1-1:0] i_gpio1_in;
  logic [W1-1:0] o_gpio1_out;
  logic [W1-1:0] o_gpio1_oe;
  logic        o_irq;

  // Register model kept masked to pin width
  logic [31:0] m_dout [0:1];
  logic [31:0] m_dir  [0:1];
  logic [31:0] m_mask [0:1];
  logic [31:0] m_stat [0:1];
  logic [31:0] m_pins [0:1];  // Settled pin values

  integer      seed;
  logic        nxt_valid;    // Address phase on the bus
  logic        nxt_write;
  logic [31:0] nxt_addr;
  logic [31:0] nxt_wdata;
  logic        cur_write;    // Transfer in data phase
  logic [31:0] cur_addr;
  logic [31:0] cur_wdata;

  apb_subsystem #(.GPIO0_W(W0), .GPIO1_W(W1)) i_dut (
    .tb_hclk23(tb_hclk23), .hresetn23(hresetn23),
    .i_hsel(i_hsel), .i_haddr(i_haddr), .i_htrans(i_htrans), .i_hwrite(i_hwrite),
    .i_hwdata(i_hwdata), .o_hrdata(o_hrdata), .o_hready(o_hready), .o_hresp(o_hresp),
    .i_gpio0_in(i_gpio0_in), .o_gpio0_out(o_gpio0_out), .o_gpio0_oe(o_gpio0_oe),
    .i_gpio1_in(i_gpio1_in), .o_gpio1_out(o_gpio1_out), .o_gpio1_oe(o_gpio1_oe),
    .o_irq(o_irq)
  );

  initial begin
    tb_hclk23 = 1'b0;
    forever #4 tb_hclk23 = ~tb_hclk23;  // 8 ns period
  end

  // ============================================================
  // Helpers
  // ============================================================
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic stop_on_timeout(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Timeout");
  endtask

  function automatic logic [31:0] pin_mask(input logic slot);
    return slot ? (32'h1 << W1) - 32'h1 : (32'h1 << W0) - 32'h1;
  endfunction

  function automatic logic [31:0] model_read(input logic slot, input logic [2:0] off);
    case (off)
      3'd0:    return m_dout[slot];
      3'd1:    return m_dir[slot];
      3'd2:    return m_pins[slot];  // Settled pins
      3'd3:    return m_mask[slot];
      3'd4:    return m_stat[slot];
      default: return 32'h0;          // Unused offsets
    endcase
  endfunction

  task automatic model_write(input logic slot, input logic [2:0] off, input logic [31:0] wd);
    case (off)
      3'd0:    m_dout[slot] = wd & pin_mask(slot);
      3'd1:    m_dir[slot]  = wd & pin_mask(slot);
      3'd3:    m_mask[slot] = wd & pin_mask(slot);
      3'd4:    m_stat[slot] = m_stat[slot] & ~wd;  // W1C
      default: ;                                     // Read only or unused
    endcase
  endtask

  // Random next transfer mostly to slots 0 and 1
  task automatic pick_next();
    logic [31:0] r;
    logic [31:0] hi;
    logic [3:0]  slot;
    r  = $random(seed);
    hi = $random(seed);
    if (r[7:5] == 3'd0) slot = r[11:8] | 4'd2;  // Unmapped
    else slot = {3'b000, r[4]};
    nxt_valid = (r[13:12] != 2'b00);
    nxt_write = r[14];
    nxt_addr  = {hi[31:16], slot, hi[11:5], r[17:15], 2'b00};
    nxt_wdata = $random(seed);
  endtask

  task automatic drive_addr();
    logic [31:0] r;
    r = $random(seed);
    i_haddr  <= nxt_addr;
    i_hwrite <= nxt_write;
    if (nxt_valid) begin
      i_hsel   <= 1'b1;
      i_htrans <= r[0] ? apb_subsystem_pkg::HTRANS_SEQ : apb_subsystem_pkg::HTRANS_NONSEQ;
    end else if (r[1]) begin
      i_hsel   <= 1'b1;  // Selected but idle or busy
      i_htrans <= r[0] ? apb_subsystem_pkg::HTRANS_BUSY : apb_subsystem_pkg::HTRANS_IDLE;
    end else begin
      i_hsel   <= 1'b0;  // Unselected with any transfer type
      i_htrans <= r[3:2];
    end
  endtask

  task automatic check_pins();
    check_value("o_gpio0_out", 32'(o_gpio0_out), m_dout[0]);
    check_value("o_gpio0_oe",  32'(o_gpio0_oe),  m_dir[0]);
    check_value("o_gpio1_out", 32'(o_gpio1_out), m_dout[1]);
    check_value("o_gpio1_oe",  32'(o_gpio1_oe),  m_dir[1]);
    check_value("o_irq", 32'(o_irq),
                32'((|(m_stat[0] & m_mask[0])) | (|(m_stat[1] & m_mask[1]))));
  endtask

  // New pin values then 4 idle cycles to settle
  task automatic change_pins();
    logic [31:0] p0;
    logic [31:0] p1;
    p0 = $random(seed) & pin_mask(1'b0);
    p1 = $random(seed) & pin_mask(1'b1);
    m_stat[0] = m_stat[0] | (p0 & ~m_pins[0]);  // Rising edges only
    m_stat[1] = m_stat[1] | (p1 & ~m_pins[1]);
    m_pins[0] = p0;
    m_pins[1] = p1;
    i_gpio0_in <= p0[W0-1:0];
    i_gpio1_in <= p1[W1-1:0];
    repeat (4) @(posedge tb_hclk23);
  endtask

  // Runs from the accept edge to the access cycle
  task automatic run_data_phase();
    logic       err;
    logic       slot;
    logic [2:0] off;
    logic       issued;
    int         lows;
    err    = (cur_addr[15:12] > 4'd1);
    slot   = cur_addr[12];
    off    = cur_addr[4:2];
    issued = 1'b0;
    lows   = 0;
    @(negedge tb_hclk23);
    check_pins();
    while (o_hready !== 1'b1) begin
      lows = lows + 1;
      if (lows > READY_LIMIT) stop_on_timeout("No o_hready after a transfer was accepted");
      check_value("o_hresp", 32'(o_hresp), 32'(err));
      @(posedge tb_hclk23);
      if (!issued) begin  // Next address during access
        pick_next();
        drive_addr();
        issued = 1'b1;
      end
      @(negedge tb_hclk23);
    end
    check_value("o_hready_low_cycles", 32'(lows), 32'd1);
    check_value("o_hresp", 32'(o_hresp), 32'(err));
    if (!err) begin
      if (cur_write) model_write(slot, off, cur_wdata);  // Lands at end of access
      else check_value("o_hrdata", o_hrdata, model_read(slot, off));
    end
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    seed       = 46;
    hresetn23  = 1'b0;
    i_hsel     = 1'b0;
    i_haddr    = 32'h0;
    i_htrans   = apb_subsystem_pkg::HTRANS_IDLE;
    i_hwrite   = 1'b0;
    i_hwdata   = 32'h0;
    i_gpio0_in = '0;
    i_gpio1_in = '0;
    for (int s = 0; s < 2; s++) begin
      m_dout[s] = 32'h0;
      m_dir[s]  = 32'h0;
      m_mask[s] = 32'h0;
      m_stat[s] = 32'h0;
      m_pins[s] = 32'h0;
    end
    nxt_valid = 1'b0;
    repeat (2) @(posedge tb_hclk23);
    hresetn23 <= 1'b1;
    @(negedge tb_hclk23);
    check_value("o_hready", 32'(o_hready), 32'd1);
    check_value("o_hresp", 32'(o_hresp), 32'd0);
    check_pins();
    @(posedge tb_hclk23);
    pick_next();
    drive_addr();
    for (int step = 0; step < NUM_STEPS; step++) begin
      @(posedge tb_hclk23);  // Accept edge when nxt_valid
      if (nxt_valid) begin
        cur_addr  = nxt_addr;
        cur_write = nxt_write;
        cur_wdata = nxt_wdata;
        i_hwdata <= cur_wdata;
        run_data_phase();
      end else begin
        if (({$random(seed)} % 6) == 0) change_pins();
        pick_next();
        drive_addr();
        @(negedge tb_hclk23);
        check_value("o_hready", 32'(o_hready), 32'd1);  // No request was taken
        check_value("o_hresp", 32'(o_hresp), 32'd0);
        check_pins();
      end
    end
    @(posedge tb_hclk23);
    @(negedge tb_hclk23);
    check_pins();  // Last write visible
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: apb_subsystem.f
rtl/apb_subsystem_pkg.sv
rtl/ahb_addr_decode.sv
rtl/apb_bridge_fsm.sv
rtl/apb_gpio.sv
rtl/apb_subsystem.sv
tests/apb_subsystem_checker.sv
tests/tb_apb_subsystem.sv

// File: Makefile
TOP = tb_apb_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f apb_subsystem.f -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f apb_subsystem.f

clean:
	rm -rf obj_dir
